// ==== include/div_settings.svh ====
`ifndef DIV_SETTINGS_SVH
`define DIV_SETTINGS_SVH

// Operand width of the divide unit
`define DIV_WIDTH 32

// Queue depths in entries
`define JOB_FIFO_DEPTH 4
`define RES_FIFO_DEPTH 4

// Register map, byte offsets
`define REG_OPA    8'h00
`define REG_OPB    8'h04
`define REG_CMD    8'h08
`define REG_STATUS 8'h0C
`define REG_QUOT   8'h10
`define REG_REM    8'h14

`endif

// ==== hw/apb_pkg.sv ====
package apb_pkg;

	////////////////////
	// APB bus signals
	////////////////////

	// Everything the master drives
	typedef struct packed {
		logic [7:0]  paddr;
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [31:0] pwdata;
	} apb_req_t;

	// Everything the slave drives
	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;   // only meaningful with pready
	} apb_rsp_t;

endpackage

// ==== hw/div_types_pkg.sv ====
`include "div_settings.svh"

package div_types_pkg;

	////////////////////
	// Divide unit payloads
	////////////////////

	// One queued division request
	typedef struct packed {
		logic [`DIV_WIDTH-1:0] dividend;
		logic [`DIV_WIDTH-1:0] divisor;
		logic                  is_signed;
	} div_job_t;

	// One finished division
	typedef struct packed {
		logic [`DIV_WIDTH-1:0] quotient;
		logic [`DIV_WIDTH-1:0] remainder;
		logic                  div_by_zero;
	} div_result_t;

endpackage

// ==== hw/apb_div_regs.sv ====
`timescale 1ns/10ps
`include "div_settings.svh"

module apb_div_regs
	import apb_pkg::*;
	import div_types_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n_i,
	input  apb_req_t    apb_req_i,
	output apb_rsp_t    apb_rsp_o,
	output div_job_t    job_o,
	output logic        job_valid_o,
	input  logic        job_full_i,
	input  div_result_t res_i,
	input  logic        res_valid_i,
	output logic        res_pop_o,
	input  logic        div_busy_i,
	input  logic        job_pending_i
);

	logic [`DIV_WIDTH-1:0] opa_q;
	logic [`DIV_WIDTH-1:0] opb_q;

	logic        access;
	logic        wr_en;
	logic        rd_en;
	logic        res_read;
	logic        res_wait;
	logic        done;
	logic        err;
	logic [31:0] rdata;

	////////////////////
	// Access decode
	////////////////////

	assign access = apb_req_i.psel && apb_req_i.penable;
	assign wr_en  = access && apb_req_i.pwrite;
	assign rd_en  = access && !apb_req_i.pwrite;

	// Result reads stall while a job is still in flight
	assign res_read = rd_en && ((apb_req_i.paddr == `REG_QUOT) ||
		(apb_req_i.paddr == `REG_REM));
	assign res_wait = res_read && !res_valid_i && (job_pending_i || div_busy_i);
	assign done     = access && !res_wait;

	always_comb begin
		err   = 1'b0;
		rdata = '0;
		case (apb_req_i.paddr)
			`REG_OPA: rdata = opa_q;
			`REG_OPB: rdata = opb_q;
			`REG_CMD: err = apb_req_i.pwrite && job_full_i;
			`REG_STATUS: begin
				rdata = {29'd0, res_valid_i && res_i.div_by_zero, job_full_i, res_valid_i};
			end
			`REG_QUOT: begin
				rdata = res_i.quotient;
				err   = !apb_req_i.pwrite && !res_valid_i;
			end
			`REG_REM: begin
				rdata = res_i.remainder;
				err   = !apb_req_i.pwrite && !res_valid_i;
			end
			default: err = 1'b1;
		endcase
	end

	////////////////////
	// Operand registers
	////////////////////

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			opa_q <= '0;
			opb_q <= '0;
		end else begin
			if (wr_en && (apb_req_i.paddr == `REG_OPA)) begin
				opa_q <= apb_req_i.pwdata;
			end
			if (wr_en && (apb_req_i.paddr == `REG_OPB)) begin
				opb_q <= apb_req_i.pwdata;
			end
		end
	end

	// Job is pushed on the completing CMD write
	assign job_o.dividend  = opa_q;
	assign job_o.divisor   = opb_q;
	assign job_o.is_signed = apb_req_i.pwdata[0];
	assign job_valid_o     = done && apb_req_i.pwrite &&
		(apb_req_i.paddr == `REG_CMD) && !job_full_i;

	// REM read consumes the head result
	assign res_pop_o = done && !apb_req_i.pwrite &&
		(apb_req_i.paddr == `REG_REM) && res_valid_i;

	assign apb_rsp_o.prdata  = rdata;
	assign apb_rsp_o.pready  = !res_wait;
	assign apb_rsp_o.pslverr = done && err;

	a_err_with_ready: assert property (@(posedge clk) disable iff (!arst_n_i)
		apb_rsp_o.pslverr |-> apb_rsp_o.pready)
		else $error("pslverr raised without pready");

endmodule

// ==== hw/sync_fifo.sv ====
`timescale 1ns/10ps

module sync_fifo #(
	parameter type item_t = logic [31:0],
	parameter int  DEPTH  = 4
) (
	input  logic  clk,
	input  logic  arst_n_i,
	input  logic  push_i,
	input  item_t data_i,
	output logic  full_o,
	input  logic  pop_i,
	output item_t data_o,
	output logic  valid_o
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	item_t            mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] count_q;

	// Wrap for depths that are not a power of two
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	always_ff @(posedge clk) begin
		if (push_i) begin
			mem[wr_ptr_q] <= data_i;
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (push_i) begin
				wr_ptr_q <= ptr_next(wr_ptr_q);
			end
			if (pop_i) begin
				rd_ptr_q <= ptr_next(rd_ptr_q);
			end
			case ({push_i, pop_i})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	// Head is shown straight from storage
	assign data_o  = mem[rd_ptr_q];
	assign valid_o = (count_q != '0);
	assign full_o  = (count_q == CNT_W'(DEPTH));

	a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n_i)
		push_i |-> !full_o)
		else $error("push into full FIFO");

	a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n_i)
		pop_i |-> valid_o)
		else $error("pop from empty FIFO");

endmodule

// ==== hw/restoring_divider.sv ====
`timescale 1ns/10ps
`include "div_settings.svh"

module restoring_divider
	import div_types_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n_i,
	input  div_job_t    job_i,
	input  logic        job_valid_i,
	output logic        job_ready_o,
	output div_result_t res_o,
	output logic        res_valid_o,
	input  logic        res_ready_i,
	output logic        busy_o
);

	localparam int W     = `DIV_WIDTH;
	localparam int CNT_W = $clog2(W + 1);

	typedef enum logic [2:0] {
		s_idle,
		s_zero,
		s_iterate,
		s_fix,
		s_done
	} state_t;

	state_t           state_q;
	logic [CNT_W-1:0] cnt_q;

	// Dividend shifts out of quo_q as quotient bits shift in
	logic [W-1:0] quo_q;
	logic [W-1:0] rem_q;
	logic [W-1:0] dvs_q;
	logic         sgn_q;
	logic         neg_quo_q;
	logic         neg_rem_q;
	logic         dbz_q;
	div_result_t  res_q;

	logic [W:0]   shifted;
	logic [W+1:0] trial;
	logic         borrow;

	logic accept;

	assign accept = job_valid_i && (state_q == s_idle);

	// Trial subtraction of one iteration
	assign shifted = {rem_q, quo_q[W-1]};
	assign trial   = {1'b0, shifted} - {2'b00, dvs_q};
	assign borrow  = trial[W+1];

	////////////////////
	// Control FSM
	////////////////////

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= s_idle;
			cnt_q   <= '0;
		end else begin
			case (state_q)
				s_idle: begin
					cnt_q <= '0;
					if (accept) begin
						state_q <= (job_i.divisor == '0) ? s_zero : s_iterate;
					end
				end
				s_zero: state_q <= s_fix;
				s_iterate: begin
					// Count 0 is the load step, counts 1 to W iterate
					cnt_q <= cnt_q + 1'b1;
					if (cnt_q == CNT_W'(W)) begin
						state_q <= s_fix;
					end
				end
				s_fix: state_q <= s_done;
				s_done: begin
					if (res_ready_i) begin
						state_q <= s_idle;
					end
				end
				default: state_q <= s_idle;
			endcase
		end
	end

	////////////////////
	// Datapath
	////////////////////

	always_ff @(posedge clk) begin
		case (state_q)
			s_idle: begin
				if (accept) begin
					quo_q     <= job_i.dividend;
					dvs_q     <= job_i.divisor;
					sgn_q     <= job_i.is_signed;
					neg_quo_q <= job_i.is_signed && (job_i.dividend[W-1] ^ job_i.divisor[W-1]);
					neg_rem_q <= job_i.is_signed && job_i.dividend[W-1];
					dbz_q     <= (job_i.divisor == '0);
				end
			end
			s_zero: begin
				quo_q <= '0;
				rem_q <= '0;
			end
			s_iterate: begin
				if (cnt_q == '0) begin
					// Take magnitudes of signed operands
					rem_q <= '0;
					if (sgn_q && quo_q[W-1]) begin
						quo_q <= -quo_q;
					end
					if (sgn_q && dvs_q[W-1]) begin
						dvs_q <= -dvs_q;
					end
				end else begin
					rem_q <= borrow ? shifted[W-1:0] : trial[W-1:0];
					quo_q <= {quo_q[W-2:0], ~borrow};
				end
			end
			s_fix: begin
				res_q.quotient    <= neg_quo_q ? -quo_q : quo_q;
				res_q.remainder   <= neg_rem_q ? -rem_q : rem_q;
				res_q.div_by_zero <= dbz_q;
			end
			default: ;
		endcase
	end

	assign job_ready_o = (state_q == s_idle);
	assign res_valid_o = (state_q == s_done);
	assign res_o       = res_q;
	assign busy_o      = (state_q != s_idle);

	a_divisor_nonzero: assert property (@(posedge clk) disable iff (!arst_n_i)
		(state_q == s_iterate) |-> (dvs_q != '0))
		else $error("zero divisor reached the iteration loop");

endmodule

// ==== hw/div_subsystem_top.sv ====
`timescale 1ns/10ps
`include "div_settings.svh"

module div_subsystem_top
	import apb_pkg::*;
	import div_types_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n_i,
	input  apb_req_t apb_req_i,
	output apb_rsp_t apb_rsp_o
);

	div_job_t    push_job;
	logic        push_job_valid;
	logic        job_full;
	div_job_t    job_head;
	logic        job_valid;
	logic        job_ready;
	logic        job_pop;
	div_result_t div_res;
	logic        div_res_valid;
	logic        res_full;
	logic        res_push;
	div_result_t res_head;
	logic        res_valid;
	logic        res_pop;
	logic        div_busy;

	// Handshake transfers
	assign job_pop  = job_valid && job_ready;
	assign res_push = div_res_valid && !res_full;

	apb_div_regs u_regs (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.apb_req_i     (apb_req_i),
		.apb_rsp_o     (apb_rsp_o),
		.job_o         (push_job),
		.job_valid_o   (push_job_valid),
		.job_full_i    (job_full),
		.res_i         (res_head),
		.res_valid_i   (res_valid),
		.res_pop_o     (res_pop),
		.div_busy_i    (div_busy),
		.job_pending_i (job_valid)
	);

	sync_fifo #(
		.item_t (div_job_t),
		.DEPTH  (`JOB_FIFO_DEPTH)
	) u_job_fifo (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.push_i   (push_job_valid),
		.data_i   (push_job),
		.full_o   (job_full),
		.pop_i    (job_pop),
		.data_o   (job_head),
		.valid_o  (job_valid)
	);

	restoring_divider u_divider (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.job_i       (job_head),
		.job_valid_i (job_valid),
		.job_ready_o (job_ready),
		.res_o       (div_res),
		.res_valid_o (div_res_valid),
		.res_ready_i (!res_full),
		.busy_o      (div_busy)
	);

	sync_fifo #(
		.item_t (div_result_t),
		.DEPTH  (`RES_FIFO_DEPTH)
	) u_res_fifo (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.push_i   (res_push),
		.data_i   (div_res),
		.full_o   (res_full),
		.pop_i    (res_pop),
		.data_o   (res_head),
		.valid_o  (res_valid)
	);

endmodule

// ==== test/tb_div_subsystem.sv ====
`timescale 1ns/10ps
`include "div_settings.svh"

module tb_div_subsystem
	import apb_pkg::*;
	import div_types_pkg::*;
;

	localparam int NUM_TESTS       = 6;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * 9 * 40 + 16 + 1000;

	logic        clk;
	logic        arst_n;
	apb_req_t    apb_req;
	apb_rsp_t    apb_rsp;
	logic [31:0] rng_state;
	int          last_wait;

	div_subsystem_top UUT (
		.clk       (clk),
		.arst_n_i  (arst_n),
		.apb_req_i (apb_req),
		.apb_rsp_o (apb_rsp)
	);

	always #10 clk = ~clk;

	////////////////////
	// Helpers
	////////////////////

	function automatic logic [31:0] xorshift32();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// Expected result from the truncating, dividend-signed rules
	function automatic div_result_t model_divide(input logic [31:0] a, input logic [31:0] b,
		input logic s);
		div_result_t      r;
		logic signed [31:0] sa;
		logic signed [31:0] sb;
		sa = a;
		sb = b;
		r  = '0;
		if (b == 32'd0) begin
			r.div_by_zero = 1'b1;
		end else if (!s) begin
			r.quotient  = a / b;
			r.remainder = a % b;
		end else if ((a == 32'h8000_0000) && (b == 32'hffff_ffff)) begin
			// Overflow case wraps
			r.quotient  = 32'h8000_0000;
			r.remainder = 32'd0;
		end else begin
			r.quotient  = sa / sb;
			r.remainder = sa % sb;
		end
		return r;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Fail: %s got 0x%h expected 0x%h", name, actual, expected);
			$display("SIMULATION FAILED");
			$fatal(1, "stopping on first error");
		end
	endtask

	// One APB transfer, sampled at the falling edge
	task automatic apb_transfer(input logic write, input logic [7:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int waits;
		@(posedge clk);
		apb_req.paddr   <= addr;
		apb_req.psel    <= 1'b1;
		apb_req.penable <= 1'b0;
		apb_req.pwrite  <= write;
		apb_req.pwdata  <= wdata;
		@(posedge clk);
		apb_req.penable <= 1'b1;
		waits = 0;
		@(negedge clk);
		while (!apb_rsp.pready) begin
			waits++;
			@(negedge clk);
		end
		rdata     = apb_rsp.prdata;
		err       = apb_rsp.pslverr;
		last_wait = waits;
		@(posedge clk);
		apb_req.psel    <= 1'b0;
		apb_req.penable <= 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
		logic [31:0] unused_rdata;
		apb_transfer(1'b1, addr, data, unused_rdata, err);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
		apb_transfer(1'b0, addr, 32'd0, data, err);
	endtask

	task automatic push_job(input logic [31:0] a, input logic [31:0] b, input logic s);
		logic err;
		apb_write(`REG_OPA, a, err);
		check_value("OPA pslverr", 32'(err), 32'd0);
		apb_write(`REG_OPB, b, err);
		check_value("OPB pslverr", 32'(err), 32'd0);
		apb_write(`REG_CMD, {31'd0, s}, err);
		check_value("CMD pslverr", 32'(err), 32'd0);
	endtask

	// QUOT waits for the head, REM pops it
	task automatic read_result(input div_result_t expected);
		logic [31:0] data;
		logic        err;
		apb_read(`REG_QUOT, data, err);
		check_value("QUOT pslverr", 32'(err), 32'd0);
		check_value("quotient", data, expected.quotient);
		apb_read(`REG_STATUS, data, err);
		check_value("STATUS result available", 32'(data[0]), 32'd1);
		check_value("STATUS div_by_zero", 32'(data[2]), 32'(expected.div_by_zero));
		apb_read(`REG_REM, data, err);
		check_value("REM pslverr", 32'(err), 32'd0);
		check_value("remainder", data, expected.remainder);
	endtask

	task automatic divide_and_check(input logic [31:0] a, input logic [31:0] b, input logic s);
		push_job(a, b, s);
		read_result(model_divide(a, b, s));
	endtask

	////////////////////
	// Directed tests
	////////////////////

	task automatic reset_state_checks();
		logic [31:0] data;
		logic        err;
		apb_read(`REG_STATUS, data, err);
		check_value("STATUS", data, 32'd0);
		// Nothing pending so the read errors at once
		apb_read(`REG_REM, data, err);
		check_value("REM pslverr", 32'(err), 32'd1);
		check_value("REM wait cycles", 32'(last_wait), 32'd0);
	endtask

	task automatic unsigned_division();
		divide_and_check(32'd100, 32'd7, 1'b0);
		divide_and_check(32'hffff_ffff, 32'd1, 1'b0);
		divide_and_check(32'd5, 32'd9, 1'b0);
		divide_and_check(32'd0, 32'd3, 1'b0);
	endtask

	task automatic signed_division();
		divide_and_check(32'd100, 32'd7, 1'b1);
		divide_and_check(-32'sd100, 32'd7, 1'b1);
		divide_and_check(32'd100, -32'sd7, 1'b1);
		divide_and_check(-32'sd100, -32'sd7, 1'b1);
		divide_and_check(32'h8000_0000, 32'hffff_ffff, 1'b1);
	endtask

	task automatic divide_by_zero();
		divide_and_check(32'd1234, 32'd0, 1'b0);
		divide_and_check(-32'sd5, 32'd0, 1'b1);
	endtask

	task automatic queue_ordering();
		div_job_t    jobs [9];
		logic [31:0] data;
		logic [31:0] shift;
		logic        err;
		for (int i = 0; i < 9; i++) begin
			shift            = xorshift32();
			jobs[i].dividend = xorshift32();
			jobs[i].divisor  = xorshift32() >> shift[4:0];
			jobs[i].is_signed = shift[8];
			// Wait for room in the job FIFO
			do begin
				apb_read(`REG_STATUS, data, err);
			end while (data[1]);
			push_job(jobs[i].dividend, jobs[i].divisor, jobs[i].is_signed);
		end
		// Everything stalls once all nine are queued
		do begin
			apb_read(`REG_STATUS, data, err);
		end while (!data[1]);
		check_value("STATUS result available", 32'(data[0]), 32'd1);
		apb_write(`REG_CMD, 32'd0, err);
		check_value("tenth CMD pslverr", 32'(err), 32'd1);
		for (int i = 0; i < 9; i++) begin
			read_result(model_divide(jobs[i].dividend, jobs[i].divisor, jobs[i].is_signed));
		end
	endtask

	task automatic unmapped_access();
		logic [31:0] data;
		logic        err;
		apb_read(8'h20, data, err);
		check_value("unmapped read pslverr", 32'(err), 32'd1);
		apb_write(8'h20, 32'h1234_5678, err);
		check_value("unmapped write pslverr", 32'(err), 32'd1);
	endtask

	////////////////////
	// Run control
	////////////////////

	initial begin
		clk       = 1'b0;
		arst_n    = 1'b0;
		apb_req   = '0;
		rng_state = 32'hda25f299;
		last_wait = 0;
		repeat (16) @(posedge clk);
		arst_n <= 1'b1;
		reset_state_checks();
		unsigned_division();
		signed_division();
		divide_by_zero();
		queue_ordering();
		unmapped_access();
		$display("SIMULATION PASSED");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the tests did not finish in %0d cycles", WATCHDOG_CYCLES);
		$display("SIMULATION FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

// ==== flist.f ====
+incdir+include
hw/apb_pkg.sv
hw/div_types_pkg.sv
hw/apb_div_regs.sv
hw/sync_fifo.sv
hw/restoring_divider.sv
hw/div_subsystem_top.sv
test/tb_div_subsystem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the divide unit testbench with Verilator

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
	-f flist.f \
	--top-module tb_div_subsystem \
	-Mdir obj_dir \
	-o tb_div_subsystem &&
./obj_dir/tb_div_subsystem ||
{ echo "run_sim.sh: build or simulation failed"; exit 1; }
